/* rtl/rv_pkg.sv */
// RV32I constants and instruction views; SYSTEM and FENCE opcodes are not decoded
package rv_pkg;

    localparam int XLEN   = 32;
    localparam int REG_AW = 5;

    // Major opcodes
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_OPIMM  = 7'b0010011;
    localparam logic [6:0] OP_OP     = 7'b0110011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;

    // Load and store widths
    localparam logic [2:0] F3_B  = 3'b000;
    localparam logic [2:0] F3_H  = 3'b001;
    localparam logic [2:0] F3_W  = 3'b010;
    localparam logic [2:0] F3_BU = 3'b100;
    localparam logic [2:0] F3_HU = 3'b101;

    // [4] branch compare, [3] sub or arithmetic shift, [2:0] funct3
    typedef logic [4:0] alu_op_t;

    localparam logic [XLEN-1:0] NOP_INSTR = 32'h0000_0013; // addi x0, x0, 0

    typedef union packed {
        struct packed {
            logic [6:0]        funct7;
            logic [REG_AW-1:0] rs2;
            logic [REG_AW-1:0] rs1;
            logic [2:0]        funct3;
            logic [REG_AW-1:0] rd;
            logic [6:0]        opcode;
        } r_fmt;
        struct packed {
            logic [11:0]       imm_11_0;
            logic [REG_AW-1:0] rs1;
            logic [2:0]        funct3;
            logic [REG_AW-1:0] rd;
            logic [6:0]        opcode;
        } i_fmt;
        struct packed {
            logic [6:0]        imm_11_5;
            logic [REG_AW-1:0] rs2;
            logic [REG_AW-1:0] rs1;
            logic [2:0]        funct3;
            logic [4:0]        imm_4_0;
            logic [6:0]        opcode;
        } s_fmt;
        struct packed {
            logic              imm_12;
            logic [5:0]        imm_10_5;
            logic [REG_AW-1:0] rs2;
            logic [REG_AW-1:0] rs1;
            logic [2:0]        funct3;
            logic [3:0]        imm_4_1;
            logic              imm_11;
            logic [6:0]        opcode;
        } b_fmt;
        struct packed {
            logic [19:0]       imm_31_12;
            logic [REG_AW-1:0] rd;
            logic [6:0]        opcode;
        } u_fmt;
        struct packed {
            logic              imm_20;
            logic [9:0]        imm_10_1;
            logic              imm_11;
            logic [7:0]        imm_19_12;
            logic [REG_AW-1:0] rd;
            logic [6:0]        opcode;
        } j_fmt;
    } rv_instr_u;

endpackage

/* rtl/rv_stage_if.sv */
// Decode control bundle and forwarding sources; both are plain wires with no handshake
`timescale 1ns/10ps

interface rv_ctrl_if;
    import rv_pkg::*;

    alu_op_t           alu_op;
    logic [XLEN-1:0]   imm;
    logic [REG_AW-1:0] rd;
    logic              reg_we;
    logic              mem_we;
    logic              mem_re;
    logic              use_rs2;   // ALU operand B is rs2, not the immediate

    modport src (output alu_op, imm, rd, reg_we, mem_we, mem_re, use_rs2);
    modport dst (input  alu_op, imm, rd, reg_we, mem_we, mem_re, use_rs2);
endinterface

interface rv_fwd_if;
    import rv_pkg::*;

    logic [REG_AW-1:0] ex_rs1, ex_rs2;             // Sources of the instruction in execute
    logic [XLEN-1:0]   ex_rs1_data, ex_rs2_data;
    logic [REG_AW-1:0] ex_mem_rd, mem_wb_rd, wb_rd;
    logic              ex_mem_we, mem_wb_we, wb_we;
    logic              ex_mem_is_load;
    logic [XLEN-1:0]   ex_mem_result, mem_wb_result, wb_result;

    modport src (output ex_rs1, ex_rs2, ex_rs1_data, ex_rs2_data, ex_mem_rd, mem_wb_rd, wb_rd,
                        ex_mem_we, mem_wb_we, wb_we, ex_mem_is_load,
                        ex_mem_result, mem_wb_result, wb_result);
    modport dst (input  ex_rs1, ex_rs2, ex_rs1_data, ex_rs2_data, ex_mem_rd, mem_wb_rd, wb_rd,
                        ex_mem_we, mem_wb_we, wb_we, ex_mem_is_load,
                        ex_mem_result, mem_wb_result, wb_result);
endinterface

/* rtl/rv_decode.sv */
// Combinational RV32I decode; unknown opcodes, SYSTEM and FENCE come out as no-ops
`timescale 1ns/10ps

module rv_decode (
    input  rv_pkg::rv_instr_u           instr_i,
    rv_ctrl_if.src                      ctrl,
    output logic [rv_pkg::REG_AW-1:0]   rs1_o,
    output logic [rv_pkg::REG_AW-1:0]   rs2_o
);
    import rv_pkg::*;

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;

    assign opcode = instr_i.r_fmt.opcode;
    assign funct3 = instr_i.r_fmt.funct3;

    // Sign-extended immediates, one per format
    assign imm_i = {{20{instr_i.i_fmt.imm_11_0[11]}}, instr_i.i_fmt.imm_11_0};
    assign imm_s = {{20{instr_i.s_fmt.imm_11_5[6]}}, instr_i.s_fmt.imm_11_5,
                    instr_i.s_fmt.imm_4_0};
    assign imm_b = {{19{instr_i.b_fmt.imm_12}}, instr_i.b_fmt.imm_12, instr_i.b_fmt.imm_11,
                    instr_i.b_fmt.imm_10_5, instr_i.b_fmt.imm_4_1, 1'b0};
    assign imm_u = {instr_i.u_fmt.imm_31_12, 12'b0};
    assign imm_j = {{11{instr_i.j_fmt.imm_20}}, instr_i.j_fmt.imm_20, instr_i.j_fmt.imm_19_12,
                    instr_i.j_fmt.imm_11, instr_i.j_fmt.imm_10_1, 1'b0};

    always_comb begin
        ctrl.alu_op  = '0;                  // ADD unless told otherwise
        ctrl.imm     = '0;
        ctrl.rd      = instr_i.r_fmt.rd;
        ctrl.reg_we  = 1'b0;
        ctrl.mem_we  = 1'b0;
        ctrl.mem_re  = 1'b0;
        ctrl.use_rs2 = 1'b0;
        rs1_o        = '0;
        rs2_o        = '0;                  // Zero keeps unused fields out of the stall check
        case (opcode)
            OP_OP: begin
                ctrl.alu_op  = {1'b0, instr_i.r_fmt.funct7[5], funct3};
                ctrl.reg_we  = 1'b1;
                ctrl.use_rs2 = 1'b1;
                rs1_o        = instr_i.r_fmt.rs1;
                rs2_o        = instr_i.r_fmt.rs2;
            end
            OP_OPIMM: begin
                // imm[10] picks SRAI only on the shift-right slot
                ctrl.alu_op = {1'b0, (funct3 == 3'b101) & instr_i.i_fmt.imm_11_0[10], funct3};
                ctrl.imm    = imm_i;
                ctrl.reg_we = 1'b1;
                rs1_o       = instr_i.i_fmt.rs1;
            end
            OP_LOAD, OP_JALR: begin
                ctrl.imm    = imm_i;
                ctrl.reg_we = 1'b1;
                ctrl.mem_re = (opcode == OP_LOAD);
                rs1_o       = instr_i.i_fmt.rs1;
            end
            OP_STORE: begin
                ctrl.imm    = imm_s;
                ctrl.mem_we = 1'b1;
                rs1_o       = instr_i.s_fmt.rs1;
                rs2_o       = instr_i.s_fmt.rs2;
            end
            OP_BRANCH: begin
                ctrl.alu_op  = {2'b10, funct3};
                ctrl.imm     = imm_b;
                ctrl.use_rs2 = 1'b1;
                rs1_o        = instr_i.b_fmt.rs1;
                rs2_o        = instr_i.b_fmt.rs2;
            end
            OP_JAL: begin
                ctrl.imm    = imm_j;
                ctrl.reg_we = 1'b1;
            end
            OP_LUI, OP_AUIPC: begin
                ctrl.imm    = imm_u;
                ctrl.reg_we = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

/* rtl/rv_regfile.sv */
// x1..x31 cleared on reset; x0 reads zero; no write-through, so same-cycle reads see old data
`timescale 1ns/10ps

module rv_regfile (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [rv_pkg::REG_AW-1:0]   rs1_addr_i,
    input  logic [rv_pkg::REG_AW-1:0]   rs2_addr_i,
    input  logic [rv_pkg::REG_AW-1:0]   rd_addr_i,
    input  logic [rv_pkg::XLEN-1:0]     rd_data_i,
    input  logic                        rd_we_i,
    output logic [rv_pkg::XLEN-1:0]     rs1_data_o,
    output logic [rv_pkg::XLEN-1:0]     rs2_data_o
);
    import rv_pkg::*;

    logic [XLEN-1:0] regs [1:31];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_we_i && rd_addr_i != '0) begin
            regs[rd_addr_i] <= rd_data_i;
        end
    end

    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule

/* rtl/rv_alu.sv */
// Integer ALU; branch ops return 1 in bit 0 when the condition holds, other bits zero
`timescale 1ns/10ps

module rv_alu (
    input  rv_pkg::alu_op_t             op_i,
    input  logic [rv_pkg::XLEN-1:0]     a_i,
    input  logic [rv_pkg::XLEN-1:0]     b_i,
    output logic [rv_pkg::XLEN-1:0]     result_o
);
    import rv_pkg::*;

    logic [4:0] shamt;
    logic       lt_s, lt_u;
    logic       cond;

    assign shamt = b_i[4:0];
    assign lt_s  = $signed(a_i) < $signed(b_i);
    assign lt_u  = a_i < b_i;

    // Branch compare on funct3
    always_comb begin
        case (op_i[2:0])
            3'b000:  cond = (a_i == b_i);  // BEQ
            3'b001:  cond = (a_i != b_i);  // BNE
            3'b100:  cond = lt_s;
            3'b101:  cond = !lt_s;
            3'b110:  cond = lt_u;
            3'b111:  cond = !lt_u;
            default: cond = 1'b0;
        endcase
    end

    always_comb begin
        if (op_i[4]) begin
            result_o = {{(XLEN-1){1'b0}}, cond};
        end else begin
            case (op_i[2:0])
                3'b000:  result_o = op_i[3] ? a_i - b_i : a_i + b_i;
                3'b001:  result_o = a_i << shamt;
                3'b010:  result_o = {{(XLEN-1){1'b0}}, lt_s};
                3'b011:  result_o = {{(XLEN-1){1'b0}}, lt_u};
                3'b100:  result_o = a_i ^ b_i;
                3'b101:  result_o = op_i[3] ? XLEN'($signed(a_i) >>> shamt) : a_i >> shamt;
                3'b110:  result_o = a_i | b_i;
                default: result_o = a_i & b_i;
            endcase
        end
    end

endmodule

/* rtl/rv_hazard.sv */
// Operand forwarding for execute and load-use stall; a load in ex_mem is never a forward source
`timescale 1ns/10ps

module rv_hazard (
    rv_fwd_if.dst                       fwd,
    input  logic [6:0]                  ex_opcode_i,
    input  logic [rv_pkg::REG_AW-1:0]   id_rs1_i,
    input  logic [rv_pkg::REG_AW-1:0]   id_rs2_i,
    input  logic [rv_pkg::REG_AW-1:0]   ex_rd_i,
    input  logic                        ex_is_load_i,
    output logic [rv_pkg::XLEN-1:0]     op_a_o,
    output logic [rv_pkg::XLEN-1:0]     op_b_o,
    output logic                        stall_o
);
    import rv_pkg::*;

    logic uses_rs1, uses_rs2;

    // Youngest producer wins
    function automatic logic [XLEN-1:0] pick(input logic [REG_AW-1:0] rs,
                                             input logic [XLEN-1:0]   reg_val);
        if (rs != '0 && fwd.ex_mem_we && !fwd.ex_mem_is_load && fwd.ex_mem_rd == rs)
            return fwd.ex_mem_result;
        if (rs != '0 && fwd.mem_wb_we && fwd.mem_wb_rd == rs)
            return fwd.mem_wb_result;
        if (rs != '0 && fwd.wb_we && fwd.wb_rd == rs)
            return fwd.wb_result;
        return reg_val;
    endfunction

    assign uses_rs1 = !(ex_opcode_i == OP_LUI || ex_opcode_i == OP_AUIPC ||
                        ex_opcode_i == OP_JAL);
    assign uses_rs2 = (ex_opcode_i == OP_OP) || (ex_opcode_i == OP_STORE) ||
                      (ex_opcode_i == OP_BRANCH);

    assign op_a_o = uses_rs1 ? pick(fwd.ex_rs1, fwd.ex_rs1_data) : fwd.ex_rs1_data;
    assign op_b_o = uses_rs2 ? pick(fwd.ex_rs2, fwd.ex_rs2_data) : fwd.ex_rs2_data;

    // Load result only exists after the memory stage, so hold decode one cycle
    assign stall_o = ex_is_load_i && (ex_rd_i != '0) &&
                     ((id_rs1_i == ex_rd_i) || (id_rs2_i == ex_rd_i));

endmodule

/* rtl/rv_core.sv */
// 5-stage RV32I core; memories must answer in the same cycle, stores carry no byte enables
`timescale 1ns/10ps

module rv_core #(
    parameter logic [rv_pkg::XLEN-1:0] RESET_ADDR = 32'h0000_0000
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [rv_pkg::XLEN-1:0]     instr_data_i,
    input  logic [rv_pkg::XLEN-1:0]     mem_data_i,
    output logic [rv_pkg::XLEN-1:0]     instr_addr_o,
    output logic [rv_pkg::XLEN-1:0]     mem_addr_o,
    output logic [rv_pkg::XLEN-1:0]     mem_wdata_o,
    output logic                        mem_we_o,
    output logic                        mem_re_o
);
    import rv_pkg::*;

    rv_ctrl_if ctrl ();
    rv_fwd_if  fwd ();

    logic [XLEN-1:0]   pc, pc_next, if_id_pc;
    rv_instr_u         if_id_instr;
    logic [REG_AW-1:0] id_rs1, id_rs2;
    logic [XLEN-1:0]   rs1_data, rs2_data;

    logic [XLEN-1:0]   id_ex_pc, id_ex_rs1_data, id_ex_rs2_data, id_ex_imm;
    logic [6:0]        id_ex_opcode;
    logic [2:0]        id_ex_funct3;
    logic [REG_AW-1:0] id_ex_rs1, id_ex_rs2, id_ex_rd;
    alu_op_t           id_ex_alu_op;
    logic              id_ex_reg_we, id_ex_mem_we, id_ex_mem_re, id_ex_use_rs2;

    logic [XLEN-1:0]   ex_mem_result, ex_mem_sdata, ex_mem_pc;
    logic [6:0]        ex_mem_opcode;
    logic [2:0]        ex_mem_funct3;
    logic [REG_AW-1:0] ex_mem_rd;
    logic              ex_mem_reg_we, ex_mem_mem_we, ex_mem_mem_re;

    logic [XLEN-1:0]   mem_wb_result, wb_result;  // wb_* is the extra forward-only stage
    logic [REG_AW-1:0] mem_wb_rd, wb_rd;
    logic              mem_wb_reg_we, wb_reg_we;

    logic [XLEN-1:0]   op_a, op_b, alu_a, alu_b, alu_result, load_data, mem_result;
    logic              stall, flush;

    rv_decode u_decode (
        .instr_i (if_id_instr),
        .ctrl    (ctrl.src),
        .rs1_o   (id_rs1),
        .rs2_o   (id_rs2)
    );

    rv_regfile u_regfile (
        .clk        (clk),
        .rst_n      (rst_n),
        .rs1_addr_i (id_rs1),
        .rs2_addr_i (id_rs2),
        .rd_addr_i  (mem_wb_rd),
        .rd_data_i  (mem_wb_result),
        .rd_we_i    (mem_wb_reg_we),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    rv_alu u_alu (
        .op_i     (id_ex_alu_op),
        .a_i      (alu_a),
        .b_i      (alu_b),
        .result_o (alu_result)
    );

    rv_hazard u_hazard (
        .fwd          (fwd.dst),
        .ex_opcode_i  (id_ex_opcode),
        .id_rs1_i     (id_rs1),
        .id_rs2_i     (id_rs2),
        .ex_rd_i      (id_ex_rd),
        .ex_is_load_i (id_ex_mem_re),
        .op_a_o       (op_a),
        .op_b_o       (op_b),
        .stall_o      (stall)
    );

    assign fwd.ex_rs1         = id_ex_rs1;
    assign fwd.ex_rs2         = id_ex_rs2;
    assign fwd.ex_rs1_data    = id_ex_rs1_data;
    assign fwd.ex_rs2_data    = id_ex_rs2_data;
    assign fwd.ex_mem_rd      = ex_mem_rd;
    assign fwd.ex_mem_we      = ex_mem_reg_we;
    assign fwd.ex_mem_is_load = ex_mem_mem_re;
    assign fwd.ex_mem_result  = ex_mem_result;   // A jump is never here when its consumer executes
    assign fwd.mem_wb_rd      = mem_wb_rd;
    assign fwd.mem_wb_we      = mem_wb_reg_we;
    assign fwd.mem_wb_result  = mem_wb_result;
    assign fwd.wb_rd          = wb_rd;
    assign fwd.wb_we          = wb_reg_we;
    assign fwd.wb_result      = wb_result;

    // Execute
    assign alu_a = (id_ex_opcode == OP_AUIPC) ? id_ex_pc :
                   (id_ex_opcode == OP_LUI)   ? '0 : op_a;
    assign alu_b = id_ex_use_rs2 ? op_b : id_ex_imm;
    assign flush = (id_ex_opcode == OP_BRANCH) || (id_ex_opcode == OP_JAL) ||
                   (id_ex_opcode == OP_JALR);

    // Every control transfer redirects, taken or not, for a fixed refetch latency
    always_comb begin
        pc_next = pc + 32'd4;
        case (id_ex_opcode)
            OP_BRANCH: pc_next = alu_result[0] ? id_ex_pc + id_ex_imm : id_ex_pc + 32'd4;
            OP_JAL:    pc_next = id_ex_pc + id_ex_imm;
            OP_JALR:   pc_next = {alu_result[XLEN-1:1], 1'b0};
            default:   ;
        endcase
    end

    // Memory stage
    always_comb begin
        case (ex_mem_funct3)
            F3_B:    load_data = {{24{mem_data_i[7]}}, mem_data_i[7:0]};
            F3_H:    load_data = {{16{mem_data_i[15]}}, mem_data_i[15:0]};
            F3_W:    load_data = mem_data_i;
            F3_BU:   load_data = {24'b0, mem_data_i[7:0]};
            F3_HU:   load_data = {16'b0, mem_data_i[15:0]};
            default: load_data = '0;
        endcase
    end

    always_comb begin
        case (ex_mem_funct3)
            F3_B:    mem_wdata_o = {24'b0, ex_mem_sdata[7:0]};
            F3_H:    mem_wdata_o = {16'b0, ex_mem_sdata[15:0]};
            default: mem_wdata_o = ex_mem_sdata;
        endcase
    end

    assign mem_result = ex_mem_mem_re ? load_data :
                        (ex_mem_opcode == OP_JAL || ex_mem_opcode == OP_JALR) ?
                        ex_mem_pc + 32'd4 : ex_mem_result;   // Link value

    assign instr_addr_o = pc;
    assign mem_addr_o   = ex_mem_result;
    assign mem_we_o     = ex_mem_mem_we;
    assign mem_re_o     = ex_mem_mem_re;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc            <= RESET_ADDR;
            if_id_instr   <= NOP_INSTR;
            id_ex_opcode  <= OP_OPIMM;
            id_ex_reg_we  <= 1'b0;
            id_ex_mem_we  <= 1'b0;
            id_ex_mem_re  <= 1'b0;
            ex_mem_opcode <= OP_OPIMM;
            ex_mem_reg_we <= 1'b0;
            ex_mem_mem_we <= 1'b0;
            ex_mem_mem_re <= 1'b0;
            mem_wb_reg_we <= 1'b0;
            wb_reg_we     <= 1'b0;
        end else begin
            if (!stall) begin
                pc          <= pc_next;
                if_id_instr <= instr_data_i;
            end
            if (flush)
                if_id_instr <= NOP_INSTR;
            if (flush || stall) begin  // Bubble into execute
                id_ex_opcode <= OP_OPIMM;
                id_ex_reg_we <= 1'b0;
                id_ex_mem_we <= 1'b0;
                id_ex_mem_re <= 1'b0;
            end else begin
                id_ex_opcode <= if_id_instr.r_fmt.opcode;
                id_ex_reg_we <= ctrl.reg_we;
                id_ex_mem_we <= ctrl.mem_we;
                id_ex_mem_re <= ctrl.mem_re;
            end
            ex_mem_opcode <= id_ex_opcode;
            ex_mem_reg_we <= id_ex_reg_we;
            ex_mem_mem_we <= id_ex_mem_we;
            ex_mem_mem_re <= id_ex_mem_re;
            mem_wb_reg_we <= ex_mem_reg_we;
            wb_reg_we     <= mem_wb_reg_we;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall)
            if_id_pc <= pc;
        id_ex_pc       <= if_id_pc;
        id_ex_funct3   <= if_id_instr.r_fmt.funct3;
        id_ex_rs1      <= id_rs1;
        id_ex_rs2      <= id_rs2;
        id_ex_rs1_data <= rs1_data;
        id_ex_rs2_data <= rs2_data;
        id_ex_imm      <= ctrl.imm;
        id_ex_rd       <= ctrl.rd;
        id_ex_alu_op   <= ctrl.alu_op;
        id_ex_use_rs2  <= ctrl.use_rs2;
        ex_mem_result  <= alu_result;
        ex_mem_sdata   <= op_b;            // Forwarded rs2 for stores
        ex_mem_pc      <= id_ex_pc;
        ex_mem_funct3  <= id_ex_funct3;
        ex_mem_rd      <= id_ex_rd;
        mem_wb_result  <= mem_result;
        mem_wb_rd      <= ex_mem_rd;
        wb_result      <= mem_wb_result;
        wb_rd          <= mem_wb_rd;
    end

endmodule

/* dv/rv_core_props.sv */
// Memory-port rules for rv_core; RESET_ADDR must match the core's
`timescale 1ns/10ps

module rv_core_props #(
    parameter logic [rv_pkg::XLEN-1:0] RESET_ADDR = 32'h0000_0000
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [rv_pkg::XLEN-1:0]     instr_addr_i,
    input  logic                        mem_we_i,
    input  logic                        mem_re_i
);

    // Data port is never a load and a store at once
    a_no_read_write: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(mem_we_i && mem_re_i)
    ) else $error("data port has mem_we and mem_re high together");

    a_fetch_aligned: assert property (
        @(posedge clk) disable iff (!rst_n)
        instr_addr_i[1:0] == 2'b00
    ) else $error("instruction address %08h is not word aligned", instr_addr_i);

    // Quiet ports and reset vector while in reset
    a_reset_quiet: assert property (
        @(posedge clk)
        !rst_n |-> (!mem_we_i && !mem_re_i && instr_addr_i == RESET_ADDR)
    ) else $error("memory ports not idle or PC off the reset vector during reset");

    // First fetch after reset comes from the reset vector
    a_first_fetch: assert property (
        @(posedge clk)
        $rose(rst_n) |-> (instr_addr_i == RESET_ADDR && !mem_we_i && !mem_re_i)
    ) else $error("first fetch after reset is at %08h", instr_addr_i);

endmodule

/* dv/tb_rv_core.sv */
// Runs dv/rv_prog.hex from the project root; memories are 256 words, stores are whole words
`timescale 1ns/10ps

module tb_rv_core;

    localparam logic [31:0] RESET_ADDR     = 32'h0000_0000;
    localparam int          RESET_CYCLES   = 5;
    localparam int          MEM_WORDS      = 256;
    localparam int          TIMEOUT_CYCLES = 400;   // About 3x the program with stalls and flushes
    localparam logic [31:0] DONE_ADDR      = 32'h0000_03FC;
    localparam int          N_STORES       = 14;

    // Stores in program order as the RV32I rules give them
    localparam logic [31:0] EXP_ADDR [N_STORES] = '{
        32'h300, 32'h304, 32'h308, 32'h30C, 32'h310, 32'h314, 32'h318,
        32'h31C, 32'h320, 32'h324, 32'h328, 32'h32C, 32'h330, 32'h3FC
    };
    localparam logic [31:0] EXP_DATA [N_STORES] = '{
        32'hFFFF_FFFD,   // sub after add and lui/addi chain
        32'h2FFF_FFFF,   // or of and/xor/sll/srl results
        32'h3000_0000,   // slt + sltu + sra + previous
        32'h0000_1058,   // auipc at 0x58
        32'hFFFF_FFA5,   // lb
        32'hFFFF_F0A5,   // lh
        32'h0000_00A5,   // lbu
        32'h0000_F0A5,   // lhu
        32'h0ECB_E14A,   // lw then add to itself
        32'h0000_00A5,   // sb
        32'h0000_F0A5,   // sh
        32'h0000_00E0,   // jal link
        32'h0000_00EC,   // jalr link
        32'h0000_0001    // done
    };

    logic        clk;
    logic        rst_n;
    logic [31:0] instr_data;
    logic [31:0] mem_data;
    logic [31:0] instr_addr;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic        mem_we;
    logic        mem_re;

    logic [31:0] imem [0:MEM_WORDS-1];
    logic [31:0] dmem [0:MEM_WORDS-1];
    string       store_name [N_STORES];
    int          store_idx;
    int          cycle_count;

    rv_core #(
        .RESET_ADDR (RESET_ADDR)
    ) dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr_data_i (instr_data),
        .mem_data_i   (mem_data),
        .instr_addr_o (instr_addr),
        .mem_addr_o   (mem_addr),
        .mem_wdata_o  (mem_wdata),
        .mem_we_o     (mem_we),
        .mem_re_o     (mem_re)
    );

    bind rv_core rv_core_props #(.RESET_ADDR(RESET_ADDR)) u_props (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr_addr_i (instr_addr_o),
        .mem_we_i     (mem_we_o),
        .mem_re_i     (mem_re_o)
    );

    // Both memories answer in the same cycle
    assign instr_data = imem[instr_addr[9:2]];
    assign mem_data   = mem_re ? dmem[mem_addr[9:2]] : 32'hBAD0_BAD0;  // Only valid on a read

    always #4 clk = ~clk;

    task automatic stop_with_failure();
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic report_mismatch(input string test, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("ERR %s: expected %08h, actual %08h", test, exp, act);
        stop_with_failure();
    endtask

    task automatic check_idle_ports(input string test);
        assert (mem_we == 1'b0) else report_mismatch({test, "_we"}, 32'h0, {31'b0, mem_we});
        assert (mem_re == 1'b0) else report_mismatch({test, "_re"}, 32'h0, {31'b0, mem_re});
        assert (instr_addr == RESET_ADDR) else report_mismatch({test, "_pc"}, RESET_ADDR,
                                                               instr_addr);
    endtask

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        store_idx   = 0;
        cycle_count = 0;
        store_name  = '{"alu_sub", "alu_logic", "alu_compare", "auipc", "load_lb",
                        "load_lh", "load_lbu", "load_lhu", "load_lw_use", "store_sb",
                        "store_sh", "jal_link", "jalr_link", "done"};
        for (int i = 0; i < MEM_WORDS; i++) begin
            dmem[i] = 32'hD000_0000 | (i << 2);   // Word holds its own address
        end
        dmem[32'h200 >> 2] = 32'h8765_F0A5;       // Load source with a negative byte and half
        $readmemh("dv/rv_prog.hex", imem);
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_idle_ports("reset_hold");
        end
        rst_n = 1'b1;
        #2;                                       // Settled, before the first rising edge
        check_idle_ports("first_fetch");
    end

    // Store monitor in program order
    always @(posedge clk) begin
        if (rst_n && mem_we) begin
            assert (store_idx < N_STORES) else begin
                $display("store to %08h after all expected stores were seen", mem_addr);
                stop_with_failure();
            end
            assert (mem_addr == EXP_ADDR[store_idx])
                else report_mismatch({store_name[store_idx], "_addr"}, EXP_ADDR[store_idx],
                                     mem_addr);
            assert (mem_wdata == EXP_DATA[store_idx])
                else report_mismatch(store_name[store_idx], EXP_DATA[store_idx], mem_wdata);
            dmem[mem_addr[9:2]] <= mem_wdata;
            store_idx = store_idx + 1;
            if (mem_addr == DONE_ADDR) begin
                $display("*** TEST PASSED ***");
                $finish;
            end
        end
    end

    always @(posedge clk) begin
        if (rst_n) begin
            cycle_count = cycle_count + 1;
            assert (cycle_count < TIMEOUT_CYCLES) else begin
                $display("timeout, done store not seen within %0d cycles", TIMEOUT_CYCLES);
                stop_with_failure();
            end
        end
    end

endmodule

/* dv/rv_prog.hex */
// One 32-bit instruction word per line, from address 0x000 upward
// x1 = store base 0x300, x2 = load base 0x200, marker stores go to 0x3F0
30000093 // 000 addi x1,x0,0x300
20000113 // 004 addi x2,x0,0x200
123451B7 // 008 lui  x3,0x12345
67818193 // 00C addi x3,x3,0x678
FFD00213 // 010 addi x4,x0,-3
004182B3 // 014 add  x5,x3,x4
40328333 // 018 sub  x6,x5,x3
0060A023 // 01C sw   x6,0(x1)
00400393 // 020 addi x7,x0,4
00719433 // 024 sll  x8,x3,x7
407254B3 // 028 sra  x9,x4,x7
00725533 // 02C srl  x10,x4,x7
00A445B3 // 030 xor  x11,x8,x10
00A5F633 // 034 and  x12,x11,x10
008666B3 // 038 or   x13,x12,x8
00722733 // 03C slt  x14,x4,x7
0043B7B3 // 040 sltu x15,x7,x4
00F70833 // 044 add  x16,x14,x15
00980833 // 048 add  x16,x16,x9
00D80833 // 04C add  x16,x16,x13
00D0A223 // 050 sw   x13,4(x1)
0100A423 // 054 sw   x16,8(x1)
00001897 // 058 auipc x17,0x1
0110A623 // 05C sw   x17,12(x1)
00010903 // 060 lb   x18,0(x2)
0120A823 // 064 sw   x18,16(x1)
00011983 // 068 lh   x19,0(x2)
0130AA23 // 06C sw   x19,20(x1)
00014A03 // 070 lbu  x20,0(x2)
0140AC23 // 074 sw   x20,24(x1)
00015A83 // 078 lhu  x21,0(x2)
0150AE23 // 07C sw   x21,28(x1)
00012B03 // 080 lw   x22,0(x2)
016B0BB3 // 084 add  x23,x22,x22
0370A023 // 088 sw   x23,32(x1)
03608223 // 08C sb   x22,36(x1)
03609423 // 090 sh   x22,40(x1)
06438663 // 094 beq  x7,x4 not taken
06739463 // 098 bne  x7,x7 not taken
0643C263 // 09C blt  x7,x4 not taken
06725063 // 0A0 bge  x4,x7 not taken
04726E63 // 0A4 bltu x4,x7 not taken
0443FC63 // 0A8 bgeu x7,x4 not taken
00738463 // 0AC beq  x7,x7,+8
0E00A823 // 0B0 marker
00439463 // 0B4 bne  x7,x4,+8
0E00A823 // 0B8 marker
00724463 // 0BC blt  x4,x7,+8
0E00A823 // 0C0 marker
0043D463 // 0C4 bge  x7,x4,+8
0E00A823 // 0C8 marker
0043E463 // 0CC bltu x7,x4,+8
0E00A823 // 0D0 marker
00727463 // 0D4 bgeu x4,x7,+8
0E00A823 // 0D8 marker
00800C6F // 0DC jal  x24,+8
0E00A823 // 0E0 marker
0380A623 // 0E4 sw   x24,44(x1)
010C0CE7 // 0E8 jalr x25,16(x24)
0E00A823 // 0EC marker
0390A823 // 0F0 sw   x25,48(x1)
00100D13 // 0F4 addi x26,x0,1
0FA0AE23 // 0F8 sw   x26,252(x1)
0000006F // 0FC jal  x0,0
0E00A823 // 100 marker, target of the not-taken branches

/* list.f */
rtl/rv_pkg.sv
rtl/rv_stage_if.sv
rtl/rv_decode.sv
rtl/rv_regfile.sv
rtl/rv_alu.sv
rtl/rv_hazard.sv
rtl/rv_core.sv
dv/rv_core_props.sv
dv/tb_rv_core.sv

/* Makefile */
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for failure"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module tb_rv_core -f list.f \
		--Mdir obj_dir -o sim_rv_core
	-./obj_dir/sim_rv_core > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF '*** TEST FAILED ***' $(LOG); then exit 1; fi
	@if ! grep -qF '*** TEST PASSED ***' $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
